// File: Bender.yml
package:
  name: rv_core

sources:
  - hw/rv_core_pkg.sv
  - hw/decode_unit.sv
  - hw/register_file.sv
  - hw/execute_unit.sv
  - hw/result_unit.sv
  - hw/rv_core_top.sv
  - target: simulation
    files:
      - verification/rv_core_props.sv
      - verification/rv_core_tb.sv

// File: all.f
hw/rv_core_pkg.sv
hw/decode_unit.sv
hw/register_file.sv
hw/execute_unit.sv
hw/result_unit.sv
hw/rv_core_top.sv
verification/rv_core_props.sv
verification/rv_core_tb.sv

// File: hw/decode_unit.sv
`timescale 1ns/10ps

module decode_unit (
    input rv_core_pkg::word_t instr,
    output rv_core_pkg::decoded_t dec
);

    logic [6:0] opcode;
    rv_core_pkg::reg_idx_t rd;
    rv_core_pkg::ctrl_t ctrl;
    rv_core_pkg::word_t imm_i;
    rv_core_pkg::word_t imm_s;
    rv_core_pkg::word_t imm_b;

    assign opcode = instr[6:0];
    assign rd = instr[11:7];

    // sign-extended immediates for each format.
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

    always_comb begin
        ctrl = '0;
        ctrl.alu_class = rv_core_pkg::CLASS_ADDR;
        dec.imm = '0;
        case (opcode)
            rv_core_pkg::OPC_RTYPE: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_class = rv_core_pkg::CLASS_FUNCT;
            end
            rv_core_pkg::OPC_ITYPE: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src = 1'b1;
                ctrl.alu_class = rv_core_pkg::CLASS_FUNCT;
                dec.imm = imm_i;
            end
            rv_core_pkg::OPC_LOAD: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src = 1'b1;
                ctrl.mem_read = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                dec.imm = imm_i;
            end
            rv_core_pkg::OPC_STORE: begin
                ctrl.alu_src = 1'b1;
                ctrl.mem_write = 1'b1;
                dec.imm = imm_s;
            end
            rv_core_pkg::OPC_BRANCH: begin
                ctrl.branch = 1'b1;
                ctrl.alu_class = rv_core_pkg::CLASS_BRANCH;
                dec.imm = imm_b;
            end
            default: begin
                // unknown opcode runs as a no-op.
                ctrl = '0;
            end
        endcase

        // x0 is never written.
        if (rd == '0) begin
            ctrl.reg_write = 1'b0;
        end

        dec.ctrl = ctrl;
        dec.rs1 = instr[19:15];
        dec.rs2 = instr[24:20];
        dec.rd = rd;
        dec.funct3 = instr[14:12];
        dec.funct7_5 = instr[30];
    end

endmodule

// File: hw/execute_unit.sv
`timescale 1ns/10ps

module execute_unit (
    input rv_core_pkg::word_t pc,
    input rv_core_pkg::decoded_t dec,
    input rv_core_pkg::word_t rs1_data,
    input rv_core_pkg::word_t rs2_data,
    output rv_core_pkg::exec_t ex,
    output rv_core_pkg::word_t next_pc
);

    rv_core_pkg::alu_op_t alu_op;
    rv_core_pkg::word_t operand_b;
    rv_core_pkg::word_t alu_result;
    logic zero;

    // alu control.
    always_comb begin
        case (dec.ctrl.alu_class)
            rv_core_pkg::CLASS_ADDR: alu_op = rv_core_pkg::ALU_ADD;
            rv_core_pkg::CLASS_BRANCH: alu_op = rv_core_pkg::ALU_SUB;
            default: begin
                case (dec.funct3)
                    // funct7 bit only matters for register operands.
                    3'b000: alu_op = (dec.funct7_5 && !dec.ctrl.alu_src) ?
                                     rv_core_pkg::ALU_SUB : rv_core_pkg::ALU_ADD;
                    3'b010: alu_op = rv_core_pkg::ALU_SLT;
                    3'b110: alu_op = rv_core_pkg::ALU_OR;
                    3'b111: alu_op = rv_core_pkg::ALU_AND;
                    default: alu_op = rv_core_pkg::ALU_ADD;
                endcase
            end
        endcase
    end

    assign operand_b = dec.ctrl.alu_src ? dec.imm : rs2_data;

    always_comb begin
        alu_result = '0;
        case (alu_op)
            rv_core_pkg::ALU_SUB: alu_result = rs1_data - operand_b;
            rv_core_pkg::ALU_AND: alu_result = rs1_data & operand_b;
            rv_core_pkg::ALU_OR: alu_result = rs1_data | operand_b;
            rv_core_pkg::ALU_SLT: alu_result[0] = $signed(rs1_data) < $signed(operand_b);
            default: alu_result = rs1_data + operand_b;
        endcase
    end

    assign zero = (alu_result == '0);

    // taken beq goes to pc + imm.
    always_comb begin
        if (dec.ctrl.branch && zero) begin
            next_pc = pc + dec.imm;
        end else begin
            next_pc = pc + rv_core_pkg::XLEN'(rv_core_pkg::PC_STEP);
        end
    end

    assign ex.alu_result = alu_result;
    assign ex.store_data = rs2_data;

endmodule

// File: hw/register_file.sv
`timescale 1ns/10ps

module register_file (
    input logic CLK,
    input logic RESET_N,
    input rv_core_pkg::reg_idx_t rs1,
    input rv_core_pkg::reg_idx_t rs2,
    input rv_core_pkg::wb_t wb,
    output rv_core_pkg::word_t rs1_data,
    output rv_core_pkg::word_t rs2_data
);

    // x0 has no storage.
    rv_core_pkg::word_t regs [1:31];

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid && (wb.rd != '0)) begin
            regs[wb.rd] <= wb.data;
        end
    end

    always_comb begin
        if (rs1 == '0) begin
            rs1_data = '0;
        end else begin
            rs1_data = regs[rs1];
        end
    end

    always_comb begin
        if (rs2 == '0) begin
            rs2_data = '0;
        end else begin
            rs2_data = regs[rs2];
        end
    end

endmodule

// File: hw/result_unit.sv
`timescale 1ns/10ps

module result_unit (
    input logic CLK,
    input logic RESET_N,
    input rv_core_pkg::ctrl_t ctrl,
    input rv_core_pkg::reg_idx_t rd,
    input rv_core_pkg::exec_t ex,
    output rv_core_pkg::wb_t wb
);

    rv_core_pkg::word_t dmem [rv_core_pkg::DMEM_WORDS];
    logic [rv_core_pkg::DMEM_INDEX_W-1:0] index;
    rv_core_pkg::word_t load_data;

    // word index, upper address bits wrap.
    assign index = ex.alu_result[rv_core_pkg::DMEM_INDEX_W+1:2];

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            for (int i = 0; i < rv_core_pkg::DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (ctrl.mem_write) begin
            dmem[index] <= ex.store_data;
        end
    end

    always_comb begin
        if (ctrl.mem_read) begin
            load_data = dmem[index];
        end else begin
            load_data = '0;
        end
    end

    // write-back select.
    always_comb begin
        wb.valid = ctrl.reg_write && RESET_N;
        wb.rd = rd;
        if (ctrl.mem_to_reg) begin
            wb.data = load_data;
        end else begin
            wb.data = ex.alu_result;
        end
    end

endmodule

// File: hw/rv_core_pkg.sv
package rv_core_pkg;

    localparam int unsigned XLEN = 32;
    localparam int unsigned REG_ADDR_W = 5;
    localparam int unsigned DMEM_WORDS = 256;
    localparam int unsigned DMEM_INDEX_W = 8;
    localparam int unsigned PC_STEP = 4;

    // major opcodes of the supported subset.
    localparam logic [6:0] OPC_RTYPE = 7'b0110011;
    localparam logic [6:0] OPC_ITYPE = 7'b0010011;
    localparam logic [6:0] OPC_LOAD = 7'b0000011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [REG_ADDR_W-1:0] reg_idx_t;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR = 3'd3,
        ALU_SLT = 3'd4
    } alu_op_t;

    // address add, branch compare, or picked by funct fields.
    typedef enum logic [1:0] {
        CLASS_ADDR = 2'd0,
        CLASS_BRANCH = 2'd1,
        CLASS_FUNCT = 2'd2
    } alu_class_t;

    typedef struct packed {
        logic branch;
        logic mem_read;
        logic mem_write;
        logic mem_to_reg;
        logic alu_src;
        logic reg_write;
        alu_class_t alu_class;
    } ctrl_t;

    typedef struct packed {
        ctrl_t ctrl;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        logic [2:0] funct3;
        logic funct7_5;
        word_t imm;
    } decoded_t;

    typedef struct packed {
        word_t alu_result;
        word_t store_data;
    } exec_t;

    typedef struct packed {
        logic valid;
        reg_idx_t rd;
        word_t data;
    } wb_t;

endpackage

// File: hw/rv_core_top.sv
`timescale 1ns/10ps

module rv_core_top (
    input logic CLK,
    input logic RESET_N,
    output rv_core_pkg::word_t imem_addr,
    input rv_core_pkg::word_t imem_data,
    output rv_core_pkg::wb_t wb
);

    rv_core_pkg::word_t pc;
    rv_core_pkg::word_t next_pc;
    rv_core_pkg::decoded_t dec;
    rv_core_pkg::word_t rs1_data;
    rv_core_pkg::word_t rs2_data;
    rv_core_pkg::exec_t ex;

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            pc <= '0;
        end else begin
            pc <= next_pc;
        end
    end

    assign imem_addr = pc;

    decode_unit u_decode (
        .instr(imem_data),
        .dec(dec)
    );

    register_file u_regs (
        .CLK(CLK),
        .RESET_N(RESET_N),
        .rs1(dec.rs1),
        .rs2(dec.rs2),
        .wb(wb),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data)
    );

    execute_unit u_execute (
        .pc(pc),
        .dec(dec),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .ex(ex),
        .next_pc(next_pc)
    );

    // write-back also feeds the register file.
    result_unit u_result (
        .CLK(CLK),
        .RESET_N(RESET_N),
        .ctrl(dec.ctrl),
        .rd(dec.rd),
        .ex(ex),
        .wb(wb)
    );

endmodule

// File: verification/rv_core_props.sv
`timescale 1ns/10ps

module rv_core_props (
    input logic CLK,
    input logic RESET_N,
    input rv_core_pkg::word_t imem_addr,
    input rv_core_pkg::wb_t wb
);

    int error_count = 0;

    // no write-back to x0.
    assert property (@(posedge CLK) disable iff (!RESET_N) wb.valid |-> (wb.rd != '0))
        else begin
            error_count++;
            $error("write-back valid with rd of zero");
        end

    assert property (@(posedge CLK) disable iff (!RESET_N) imem_addr[1:0] == 2'b00)
        else begin
            error_count++;
            $error("fetch address not word aligned");
        end

    // reset holds write-back off.
    assert property (@(posedge CLK) !RESET_N |-> !wb.valid)
        else begin
            error_count++;
            $error("write-back valid during reset");
        end

endmodule

// File: verification/rv_core_tb.sv
`timescale 1ns/10ps

module rv_core_tb;

    localparam int NUM_INSTR = 2000;
    localparam int RESET_AT = 1000;
    localparam int RESET_TIMEOUT = 10;

    logic CLK;
    logic RESET_N;
    rv_core_pkg::word_t imem_addr;
    rv_core_pkg::word_t imem_data;
    rv_core_pkg::wb_t wb;
    integer seed;
    rv_core_pkg::word_t model_regs [32];
    rv_core_pkg::word_t model_mem [rv_core_pkg::DMEM_WORDS];
    rv_core_pkg::word_t model_pc;
    rv_core_pkg::word_t exp_pc;
    rv_core_pkg::wb_t exp_wb;
    logic exp_store;
    rv_core_pkg::word_t exp_addr;
    rv_core_pkg::word_t exp_data;

    rv_core_top DUT (
        .CLK(CLK),
        .RESET_N(RESET_N),
        .imem_addr(imem_addr),
        .imem_data(imem_data),
        .wb(wb)
    );

    bind rv_core_top rv_core_props u_props (
        .CLK(CLK),
        .RESET_N(RESET_N),
        .imem_addr(imem_addr),
        .wb(wb)
    );

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    task automatic fail_run();
        $display("Some tests failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_pc(input rv_core_pkg::word_t actual, input rv_core_pkg::word_t expected);
        if (actual !== expected) begin
            $display("mismatch at %0t: imem_addr %h, expected %h", $time, actual, expected);
            fail_run();
        end
    endtask

    task automatic check_wb(input rv_core_pkg::wb_t actual, input rv_core_pkg::wb_t expected);
        if (actual.valid !== expected.valid || (expected.valid &&
                (actual.rd !== expected.rd || actual.data !== expected.data))) begin
            $display("mismatch at %0t: wb %b x%0d %h, expected %b x%0d %h", $time,
                     actual.valid, actual.rd, actual.data,
                     expected.valid, expected.rd, expected.data);
            fail_run();
        end
    endtask

    // core and model go back to zero together.
    task automatic apply_reset();
        int waited;
        RESET_N = 1'b0;
        foreach (model_regs[i]) model_regs[i] = '0;
        foreach (model_mem[i]) model_mem[i] = '0;
        model_pc = '0;
        repeat (3) begin
            #2;
            check_wb(wb, '0);
            @(negedge CLK);
        end
        RESET_N = 1'b1;
        waited = 0;
        while (imem_addr !== '0) begin
            if (waited >= RESET_TIMEOUT) begin
                $display("timeout: fetch address did not return to zero after reset");
                fail_run();
            end
            #1;
            waited++;
        end
    endtask

    task automatic gen_instr(output rv_core_pkg::word_t instr);
        int kind;
        rv_core_pkg::reg_idx_t rd;
        rv_core_pkg::reg_idx_t rs1;
        rv_core_pkg::reg_idx_t rs2;
        logic [11:0] imm;
        logic [12:0] boff;
        logic [6:0] opc;
        kind = $unsigned($random(seed)) % 20;
        rd = $random(seed);
        rs1 = $random(seed);
        rs2 = $random(seed);
        // aligned address inside data memory.
        imm = 12'(($unsigned($random(seed)) % 256) * 4);
        if (kind < 2) begin
            opc = $random(seed);
            if (opc inside {rv_core_pkg::OPC_RTYPE, rv_core_pkg::OPC_ITYPE, rv_core_pkg::OPC_LOAD,
                            rv_core_pkg::OPC_STORE, rv_core_pkg::OPC_BRANCH})
                opc = 7'b1111111;
            instr = $random(seed);
            instr[6:0] = opc;
        end else if (kind < 8) begin
            case ($unsigned($random(seed)) % 5)
                0: instr = {7'b0000000, rs2, rs1, 3'b000, rd, rv_core_pkg::OPC_RTYPE};
                1: instr = {7'b0100000, rs2, rs1, 3'b000, rd, rv_core_pkg::OPC_RTYPE};
                2: instr = {7'b0000000, rs2, rs1, 3'b010, rd, rv_core_pkg::OPC_RTYPE};
                3: instr = {7'b0000000, rs2, rs1, 3'b110, rd, rv_core_pkg::OPC_RTYPE};
                default: instr = {7'b0000000, rs2, rs1, 3'b111, rd, rv_core_pkg::OPC_RTYPE};
            endcase
        end else if (kind < 11) begin
            imm = $random(seed);
            instr = {imm, rs1, 3'b000, rd, rv_core_pkg::OPC_ITYPE};
        end else if (kind < 14) begin
            instr = {imm, 5'd0, 3'b010, rd, rv_core_pkg::OPC_LOAD};
        end else if (kind < 17) begin
            instr = {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], rv_core_pkg::OPC_STORE};
        end else begin
            // offsets from -64 to +64, equal operands half the time.
            boff = 13'(($random(seed) % 17) * 4);
            if ($random(seed) & 1)
                rs2 = rs1;
            instr = {boff[12], boff[10:5], rs2, rs1, 3'b000, boff[4:1], boff[11],
                     rv_core_pkg::OPC_BRANCH};
        end
    endtask

    // expected effect of one instruction from the RV32I rules.
    task automatic predict(input rv_core_pkg::word_t instr);
        rv_core_pkg::word_t a;
        rv_core_pkg::word_t b;
        rv_core_pkg::word_t imm_i;
        rv_core_pkg::word_t imm_s;
        rv_core_pkg::word_t imm_b;
        a = model_regs[instr[19:15]];
        b = model_regs[instr[24:20]];
        imm_i = {{20{instr[31]}}, instr[31:20]};
        imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
        exp_wb = '0;
        exp_wb.rd = instr[11:7];
        exp_store = 1'b0;
        exp_pc = model_pc + 32'd4;
        case (instr[6:0])
            rv_core_pkg::OPC_RTYPE: begin
                exp_wb.valid = 1'b1;
                case (instr[14:12])
                    3'b000: exp_wb.data = instr[30] ? a - b : a + b;
                    3'b010: exp_wb.data = {31'b0, $signed(a) < $signed(b)};
                    3'b110: exp_wb.data = a | b;
                    default: exp_wb.data = a & b;
                endcase
            end
            rv_core_pkg::OPC_ITYPE: begin
                exp_wb.valid = 1'b1;
                exp_wb.data = a + imm_i;
            end
            rv_core_pkg::OPC_LOAD: begin
                exp_wb.valid = 1'b1;
                exp_addr = a + imm_i;
                exp_wb.data = model_mem[exp_addr[9:2]];
            end
            rv_core_pkg::OPC_STORE: begin
                exp_store = 1'b1;
                exp_addr = a + imm_s;
                exp_data = b;
            end
            rv_core_pkg::OPC_BRANCH: begin
                if (a == b)
                    exp_pc = model_pc + imm_b;
            end
            default: ;
        endcase
        if (exp_wb.rd == '0)
            exp_wb.valid = 1'b0;
    endtask

    initial begin
        rv_core_pkg::word_t instr;
        seed = 32'hd8417dcb;
        RESET_N = 1'b0;
        imem_data = '0;
        apply_reset();
        for (int n = 0; n < NUM_INSTR; n++) begin
            if (n == RESET_AT)
                apply_reset();
            if (DUT.u_props.error_count != 0) begin
                $display("assertion failure reported by the bound property checker");
                fail_run();
            end
            check_pc(imem_addr, model_pc);
            gen_instr(instr);
            imem_data = instr;
            predict(instr);
            #2;
            check_wb(wb, exp_wb);
            @(posedge CLK);
            if (exp_wb.valid)
                model_regs[exp_wb.rd] = exp_wb.data;
            if (exp_store)
                model_mem[exp_addr[9:2]] = exp_data;
            model_pc = exp_pc;
            @(negedge CLK);
        end
        if (DUT.u_props.error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("assertion failure reported by the bound property checker");
            fail_run();
        end
        $finish;
    end

endmodule
